//--- ps2_macros.svh
/* Shared defines for the PS/2 receiver: clocking, oversampling, FIFO size,
   receive timing and Wishbone register offsets. */

`ifndef PS2_MACROS_SVH
`define PS2_MACROS_SVH

// system clock and the oversampling timebase.
`define PS2_CLK_FREQ            100000000  // system clock in hz.
`define PS2_SAMPLE_RATE         204800     // 16 ticks per bit at the 12.8 khz line rate.
`define PS2_SAMPLE_DIV_DEFAULT  (`PS2_CLK_FREQ / `PS2_SAMPLE_RATE)

// receive queue.
`define PS2_FIFO_DEPTH          8          // entries held between host reads.

// deframer timing, counted in sample ticks.
`define PS2_SETTLE_TICKS        4          // low clock must hold this long before sampling.
`define PS2_IDLE_TICKS          16         // a quiet line this long drops a partial frame.

// wishbone word offsets, decoded from wb_adr[3:2].
`define PS2_REG_DATA            2'd0
`define PS2_REG_STATUS          2'd1
`define PS2_REG_CTRL            2'd2

`endif

//--- ps2_pkg.sv
/* Types for the PS/2 receiver: scan-code byte, receive event record
   and the FIFO fill level. */

`include "ps2_macros.svh"

package ps2_pkg;

	// one byte exactly as it came off the wire, no translation applied.
	typedef logic [7:0] ps2_code_t;

	//////////////////////////////////////////////////////////////
	// receive event.
	//////////////////////////////////////////////////////////////

	// field order puts frame_err at bit 9 and parity_err at bit 8,
	// so the record drops straight into the DATA register layout.
	typedef struct packed {
		logic      frame_err;  // start bit was 1 or stop bit was 0.
		logic      parity_err; // data plus parity bit did not have odd parity.
		ps2_code_t code;       // the received byte.
	} ps2_rx_event_t;

	// fill level must reach the full depth, not just depth minus one.
	typedef logic [$clog2(`PS2_FIFO_DEPTH + 1)-1:0] ps2_fifo_count_t;

endpackage

//--- ps2_line_sync.sv
/* Oversample tick divider, two-flop synchronizers and stable-level filter
   for the PS/2 clock and data inputs. */

`timescale 1ns/1ps
`include "ps2_macros.svh"

module ps2_line_sync #(
	parameter int sample_div = `PS2_SAMPLE_DIV_DEFAULT
) (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic ps2_clk,
	input  logic ps2_data,
	output logic sample_tick,
	output logic line_clk,
	output logic line_data
);

	localparam int div_w = (sample_div > 1) ? $clog2(sample_div) : 1;

	logic [div_w-1:0] div_cnt;   // counts down to the next tick.
	logic [1:0]       sync_1;    // first synchronizer stage, {clk, data}.
	logic [1:0]       sync_2;    // second stage, safe to use from here on.
	logic [1:0]       prev_samp; // raw level seen at the previous tick.
	logic [1:0]       level;     // filtered level.

	////////////////////////////////////////////////////////////
	// tick divider.
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst || sample_tick)
			div_cnt <= div_w'(sample_div - 1); // reload on every tick.
		else
			div_cnt <= div_cnt - 1'b1;
	end

	assign sample_tick = (div_cnt == '0); // one cycle wide, every sample_div cycles.

	////////////////////////////////////////////////////////////
	// synchronize and filter both lines together.
	////////////////////////////////////////////////////////////

	// both lines idle high, so the whole chain comes out of reset high.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			sync_1    <= 2'b11;
			sync_2    <= 2'b11;
			prev_samp <= 2'b11;
			level     <= 2'b11;
		end else begin
			sync_1 <= {ps2_clk, ps2_data};
			sync_2 <= sync_1;
			if (sample_tick) begin
				prev_samp <= sync_2;
				// a bit moves only when two ticks in a row agree on it.
				level <= (sync_2 & ~(sync_2 ^ prev_samp)) | (level & (sync_2 ^ prev_samp));
			end
		end
	end

	assign line_clk  = level[1];
	assign line_data = level[0];

endmodule

//--- ps2_rx_deframer.sv
/* PS/2 frame receiver: samples data on a settled low clock, shifts in the
   11-bit frame, checks framing and parity, drops stalled frames. */

`timescale 1ns/1ps
`include "ps2_macros.svh"

module ps2_rx_deframer (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  logic                  sample_tick,
	input  logic                  line_clk,
	input  logic                  line_data,
	output logic                  rx_valid,
	output ps2_pkg::ps2_rx_event_t rx_event
);

	import ps2_pkg::*;

	localparam int cnt_w = $clog2(`PS2_IDLE_TICKS + 1);

	logic             clk_level;  // line_clk level being timed.
	logic [cnt_w-1:0] stable_cnt; // ticks since line_clk last changed, saturating.
	logic [3:0]       bit_cnt;    // bits taken so far in this frame.
	logic [10:0]      shift;      // frame bits, start bit ends up in bit 0.
	logic             frame_done; // high the cycle after the eleventh sample.
	logic             take_bit;

	// the clock has sat low for the settle time, data is stable now.
	assign take_bit = sample_tick && !clk_level &&
	                  (stable_cnt == cnt_w'(`PS2_SETTLE_TICKS));

	////////////////////////////////////////////////////////////
	// clock timing and bit capture.
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			clk_level  <= 1'b1;
			stable_cnt <= '0;
			bit_cnt    <= '0;
			shift      <= '1;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (sample_tick) begin
				if (line_clk != clk_level) begin
					clk_level  <= line_clk; // edge seen, restart the timer.
					stable_cnt <= '0;
				end else if (stable_cnt != cnt_w'(`PS2_IDLE_TICKS)) begin
					stable_cnt <= stable_cnt + 1'b1;
				end
			end
			if (take_bit) begin
				shift <= {line_data, shift[10:1]}; // lsb first on the wire.
				if (bit_cnt == 4'd10) begin
					bit_cnt    <= '0; // stop bit taken.
					frame_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
			// no clock edge for a long while, so give up on the frame.
			if (sample_tick && stable_cnt == cnt_w'(`PS2_IDLE_TICKS)) begin
				bit_cnt <= '0;
				shift   <= '1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// event output.
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			rx_valid <= 1'b0;
		else
			rx_valid <= frame_done; // one pulse per complete frame.
	end

	// the event is only looked at while rx_valid is high.
	always_ff @(posedge sys_clk) begin
		if (frame_done) begin
			rx_event.code       <= shift[8:1];
			rx_event.parity_err <= ~(^shift[9:1]);       // odd parity expected.
			rx_event.frame_err  <= shift[0] | ~shift[10]; // start 0, stop 1.
		end
	end

endmodule

//--- ps2_event_fifo.sv
/* Synchronous circular FIFO with a type parameter payload and an overflow
   pulse for pushes that arrive while full. */

`timescale 1ns/1ps
`include "ps2_macros.svh"

module ps2_event_fifo #(
	parameter type payload_t = ps2_pkg::ps2_rx_event_t,
	parameter int  depth     = `PS2_FIFO_DEPTH
) (
	input  logic                     sys_clk,
	input  logic                     sys_rst,
	input  logic                     push,
	input  payload_t                 push_data,
	input  logic                     pop,
	output payload_t                 head,
	output ps2_pkg::ps2_fifo_count_t count,
	output logic                     overflow
);

	import ps2_pkg::*;

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

	payload_t         mem [depth]; // storage.
	logic [ptr_w-1:0] wr_ptr;      // next slot to write.
	logic [ptr_w-1:0] rd_ptr;      // current head slot.
	logic             full;
	logic             wr_en;
	logic             rd_en;

	assign full  = (count == ps2_fifo_count_t'(depth));
	assign wr_en = push && !full;         // no room means the event is lost.
	assign rd_en = pop && (count != '0);  // popping an empty FIFO does nothing.

	////////////////////////////////////////////////////////////
	// pointers and fill level.
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			// push and pop together leave the level where it was.
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
			overflow <= push && full; // single cycle per dropped event.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_en)
			mem[wr_ptr] <= push_data;
	end

	assign head = mem[rd_ptr]; // shows up the cycle after the first push.

endmodule

//--- ps2_wb_regs.sv
/* Wishbone classic slave for the PS/2 receiver: DATA, STATUS and CTRL
   registers, FIFO pop, sticky overflow and the level interrupt. */

`timescale 1ns/1ps
`include "ps2_macros.svh"

module ps2_wb_regs (
	input  logic                     sys_clk,
	input  logic                     sys_rst,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [3:2]               wb_adr,
	input  logic [31:0]              wb_dat_w,
	output logic [31:0]              wb_dat_r,
	output logic                     wb_ack,
	input  ps2_pkg::ps2_rx_event_t   head,
	input  ps2_pkg::ps2_fifo_count_t count,
	input  logic                     overflow,
	output logic                     pop,
	output logic                     irq
);

	import ps2_pkg::*;

	localparam int pad_w = 31 - $bits(ps2_rx_event_t); // zeros between valid and the event.

	logic        req;        // new cycle on the bus, ack goes out next edge.
	logic        not_empty;
	logic        full;
	logic        ovf_sticky; // set by a dropped event, cleared from CTRL.
	logic        irq_enable;
	logic        ctrl_wr;
	logic [31:0] rd_mux;     // read data for the addressed register.

	assign req       = wb_cyc && wb_stb && !wb_ack; // one access per strobe.
	assign not_empty = (count != '0);
	assign full      = (count == ps2_fifo_count_t'(`PS2_FIFO_DEPTH));
	assign ctrl_wr   = req && wb_we && (wb_adr == `PS2_REG_CTRL);

	////////////////////////////////////////////////////////////
	// read decode.
	////////////////////////////////////////////////////////////

	always_comb begin
		rd_mux = '0; // unmapped offsets read as zero.
		case (wb_adr)
			`PS2_REG_DATA: begin
				if (not_empty)
					rd_mux = {1'b1, {pad_w{1'b0}}, head}; // valid in bit 31.
			end
			`PS2_REG_STATUS: rd_mux = {24'd0, count, 1'b0, ovf_sticky, full, not_empty};
			`PS2_REG_CTRL:   rd_mux = {31'd0, irq_enable}; // clear bit reads back 0.
			default:         rd_mux = '0;
		endcase
	end

	// the head does not move before the pop edge, so this matches the popped entry.
	always_ff @(posedge sys_clk) begin
		if (req && !wb_we)
			wb_dat_r <= rd_mux;
		else
			wb_dat_r <= '0;
	end

	////////////////////////////////////////////////////////////
	// handshake, control state and interrupt.
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wb_ack     <= 1'b0;
			pop        <= 1'b0;
			ovf_sticky <= 1'b0;
			irq_enable <= 1'b0;
			irq        <= 1'b0;
		end else begin
			wb_ack <= req; // no wait states.
			// pop rides along with the ack of a DATA read that found an entry.
			pop <= req && !wb_we && (wb_adr == `PS2_REG_DATA) && not_empty;
			if (ctrl_wr) begin
				irq_enable <= wb_dat_w[0];
				if (wb_dat_w[1])
					ovf_sticky <= 1'b0;
			end
			if (overflow)
				ovf_sticky <= 1'b1; // a drop in the same cycle as a clear still sticks.
			irq <= irq_enable && not_empty; // level, one cycle behind the FIFO.
		end
	end

endmodule

//--- ps2_host_top.sv
/* PS/2 keyboard receiver top level: line sync, deframer, event FIFO
   and Wishbone registers. */

`timescale 1ns/1ps
`include "ps2_macros.svh"

module ps2_host_top #(
	parameter int sample_div = `PS2_SAMPLE_DIV_DEFAULT // system clocks per oversample tick.
) (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  logic        ps2_clk,
	input  logic        ps2_data,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [3:2]  wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack,
	output logic        irq
);

	import ps2_pkg::*;

	logic            sample_tick;
	logic            line_clk;
	logic            line_data;
	logic            rx_valid;
	ps2_rx_event_t   rx_event;
	ps2_rx_event_t   head;
	ps2_fifo_count_t count;
	logic            overflow;
	logic            pop;

	ps2_line_sync #(.sample_div(sample_div)) i_line_sync (
		.sys_clk, .sys_rst, .ps2_clk, .ps2_data, .sample_tick, .line_clk, .line_data
	);

	ps2_rx_deframer i_deframer (
		.sys_clk, .sys_rst, .sample_tick, .line_clk, .line_data, .rx_valid, .rx_event
	);

	// every completed frame goes into the queue, good or bad.
	ps2_event_fifo #(
		.payload_t(ps2_rx_event_t),
		.depth    (`PS2_FIFO_DEPTH)
	) i_fifo (
		.sys_clk, .sys_rst, .push(rx_valid), .push_data(rx_event), .pop,
		.head, .count, .overflow
	);

	ps2_wb_regs i_regs (
		.sys_clk, .sys_rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.wb_dat_r, .wb_ack, .head, .count, .overflow, .pop, .irq
	);

endmodule

//--- tb_ps2_host_properties.sv
/* Concurrent checks on the Wishbone handshake, the FIFO pop and the
   interrupt of the PS/2 register block. */

`timescale 1ns/1ps

module tb_ps2_host_properties (
	input logic sys_clk,
	input logic sys_rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic pop,
	input logic irq
);

	int unsigned violations = 0;

	// an ack only ever answers a live strobe.
	ack_needs_strobe: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wb_ack |-> (wb_cyc && wb_stb))
		else begin violations++; $error("wb_ack high without wb_cyc and wb_stb"); end

	ack_one_cycle: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wb_ack |=> !wb_ack) // no back to back acks on one strobe.
		else begin violations++; $error("wb_ack held for two cycles"); end

	pop_with_ack: assert property (@(posedge sys_clk) disable iff (sys_rst) pop |-> wb_ack)
		else begin violations++; $error("FIFO pop without a bus ack"); end

	irq_low_after_reset: assert property (@(posedge sys_clk) sys_rst |=> !irq)
		else begin violations++; $error("irq high in the cycle after reset"); end

endmodule

bind ps2_wb_regs tb_ps2_host_properties i_props (
	.sys_clk, .sys_rst, .wb_cyc, .wb_stb, .wb_ack, .pop, .irq
);

//--- tb_ps2_host.sv
/* Testbench for the PS/2 receiver: xorshift device model, Wishbone master,
   queue reference model, compare tasks and watchdog. */

`timescale 1ns/1ps
`include "ps2_macros.svh"

module tb_ps2_host;

	import ps2_pkg::*;

	localparam int sample_div  = 4;               // fast timebase, one tick every 40 ns.
	localparam int half_cycles = 10 * sample_div; // ps2 clock half period of 10 ticks.
	localparam int idle_cycles = 40 * sample_div; // line rest between frames.
	localparam int n_frames    = 40 + 2 + 10 + 3;
	localparam int limit_ns    = n_frames * 11 * 20 * sample_div * 10 +
	                             n_frames * idle_cycles * 10 + 100000;

	logic          sys_clk;
	logic          sys_rst;
	logic          ps2_clk;
	logic          ps2_data;
	logic          wb_cyc;
	logic          wb_stb;
	logic          wb_we;
	logic [3:2]    wb_adr;
	logic [31:0]   wb_dat_w;
	logic [31:0]   wb_dat_r;
	logic          wb_ack;
	logic          irq;
	logic [31:0]   rng;          // xorshift state.
	ps2_rx_event_t model_q[$];   // what the FIFO should hold, oldest first.
	logic          model_ovf;    // expected sticky overflow bit.
	logic          model_irq_en; // expected CTRL bit 0.

	ps2_host_top #(.sample_div(sample_div)) i_dut (.*);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	initial begin
		#(limit_ns); // every frame plus its idle gap, with slack for bus traffic.
		$display("watchdog expired before the tests completed");
		abort_run();
	end

	always @(negedge sys_clk) begin
		if (i_dut.i_regs.i_props.violations != 0) begin
			$display("an assertion on the Wishbone port or irq failed");
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////
	// helpers, device model and bus master.
	////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic logic [31:0] draw_random();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic logic expected_irq();
		return model_irq_en && (model_q.size() != 0); // level, enable and not empty.
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
	endtask

	// device side; data moves while the clock is high and holds through the low half.
	task automatic transmit_frame(input ps2_code_t code, input logic bad_par,
	                              input logic bad_stop);
		logic [10:0]   bits;
		ps2_rx_event_t ev;
		bits = {~bad_stop, ~(^code) ^ bad_par, code, 1'b0}; // stop, odd parity, data, start.
		@(posedge sys_clk);
		for (int i = 0; i < 11; i++) begin
			ps2_data <= bits[i];
			wait_cycles(half_cycles);
			ps2_clk <= 1'b0;
			wait_cycles(half_cycles);
			ps2_clk <= 1'b1;
		end
		ps2_data <= 1'b1;
		wait_cycles(idle_cycles);
		ev.code       = code;
		ev.parity_err = bad_par;
		ev.frame_err  = bad_stop;
		if (model_q.size() < `PS2_FIFO_DEPTH)
			model_q.push_back(ev);
		else
			model_ovf = 1'b1; // the FIFO drops it and flags the loss.
	endtask

	// one Wishbone classic cycle; read data is taken while ack is high.
	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
	                         output logic [31:0] rdat);
		int waits;
		waits = 0;
		@(posedge sys_clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdat;
		@(negedge sys_clk);
		while (!wb_ack && waits < 4) begin
			waits++;
			@(negedge sys_clk);
		end
		if (!wb_ack) begin
			$display("no Wishbone ack within 4 cycles");
			abort_run();
		end
		rdat = wb_dat_r;
		@(posedge sys_clk);
		wb_cyc <= 1'b0; // strobe drops right after the ack.
		wb_stb <= 1'b0;
	endtask

	task automatic write_ctrl(input logic [31:0] value);
		logic [31:0] ignored;
		wb_access(1'b1, `PS2_REG_CTRL, value, ignored);
		model_irq_en = value[0];
		if (value[1])
			model_ovf = 1'b0; // write one to clear.
	endtask

	////////////////////////////////////////////////////////////
	// compare tasks and checked reads.
	////////////////////////////////////////////////////////////

	task automatic check_event(input logic [31:0] word, input ps2_rx_event_t exp_ev,
	                           input logic exp_valid);
		ps2_rx_event_t got;
		got = ps2_rx_event_t'(word[9:0]);
		if (word[31] !== exp_valid || word[30:10] !== '0) begin
			$display("FAIL wb_dat_r[31:10] got %h exp %h", word[31:10], {exp_valid, 21'd0});
			abort_run();
		end
		if (got !== exp_ev) begin
			$display("FAIL wb_dat_r event got %h exp %h", got, exp_ev);
			abort_run();
		end
	endtask

	task automatic check_status(input logic [31:0] word, input ps2_fifo_count_t exp_count,
	                            input logic exp_full, input logic exp_ovf);
		logic [31:0] exp_word;
		exp_word = {24'd0, exp_count, 1'b0, exp_ovf, exp_full, exp_count != '0};
		if (word !== exp_word) begin
			$display("FAIL status got %h exp %h", word, exp_word);
			abort_run();
		end
	endtask

	task automatic check_irq(input logic exp);
		@(negedge sys_clk);
		if (irq !== exp) begin
			$display("FAIL irq got %h exp %h", irq, exp);
			abort_run();
		end
	endtask

	task automatic read_data();
		logic [31:0]   word;
		ps2_rx_event_t exp_ev;
		wb_access(1'b0, `PS2_REG_DATA, '0, word);
		if (model_q.size() != 0) begin
			exp_ev = model_q.pop_front();
			check_event(word, exp_ev, 1'b1);
		end else begin
			check_event(word, '0, 1'b0); // empty FIFO reads as all zero.
		end
	endtask

	task automatic read_status();
		logic [31:0] word;
		wb_access(1'b0, `PS2_REG_STATUS, '0, word);
		check_status(word, ps2_fifo_count_t'(model_q.size()),
		             model_q.size() == `PS2_FIFO_DEPTH, model_ovf);
	endtask

	// the count in STATUS marks when the last frame has landed.
	task automatic wait_for_count(input int n);
		logic [31:0] word;
		int          polls;
		polls = 0;
		do begin
			wb_access(1'b0, `PS2_REG_STATUS, '0, word);
			polls++;
		end while (int'(word[7:4]) != n && polls < 50);
		if (int'(word[7:4]) != n) begin
			$display("FIFO count never reached %0d", n);
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// test sequence.
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		sys_rst      = 1'b1;
		ps2_clk      = 1'b1; // both ps2 lines rest high.
		ps2_data     = 1'b1;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = '0;
		wb_dat_w     = '0;
		rng          = 32'h8b50;
		model_ovf    = 1'b0;
		model_irq_en = 1'b0;
		wait_cycles(4);
		sys_rst <= 1'b0;
		for (int i = 0; i < 40; i++) begin
			r = draw_random();
			transmit_frame(r[7:0], 1'b0, 1'b0);
			wait_for_count(1);
			wait_cycles(r[10:8]); // random gap before the host reads.
			read_data();
		end
		r = draw_random();
		transmit_frame(r[7:0], 1'b1, 1'b0);  // parity bit inverted.
		wait_for_count(1);
		read_data();
		transmit_frame(r[15:8], 1'b0, 1'b1); // stop bit driven low.
		wait_for_count(1);
		read_data();
		// ten frames with no reads overfill the eight entries.
		for (int i = 0; i < 10; i++) begin
			r = draw_random();
			transmit_frame(r[7:0], r[9:8] == 2'b00, 1'b0);
		end
		wait_for_count(`PS2_FIFO_DEPTH);
		read_status();
		repeat (`PS2_FIFO_DEPTH) read_data();
		write_ctrl(32'h2);
		read_status();
		read_data();   // empty FIFO.
		read_status();
		// irq follows the queue only once it is enabled.
		for (int i = 0; i < 3; i++) begin
			r = draw_random();
			transmit_frame(r[7:0], 1'b0, 1'b0);
		end
		wait_for_count(3);
		check_irq(expected_irq());
		write_ctrl(32'h1);
		while (model_q.size() != 0) begin
			check_irq(expected_irq());
			read_data();
		end
		wait_cycles(2); // pop edge, then the registered irq.
		check_irq(expected_irq());
		if (i_dut.i_regs.i_props.violations == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("an assertion on the Wishbone port or irq failed");
			abort_run();
		end
	end

endmodule

//--- vlog.f
+incdir+.
ps2_pkg.sv
ps2_line_sync.sv
ps2_rx_deframer.sv
ps2_event_fifo.sv
ps2_wb_regs.sv
ps2_host_top.sv
tb_ps2_host_properties.sv
tb_ps2_host.sv
